//--- src/uart_pkg.sv
`default_nettype none

package uart_pkg;

    // The clock is scaled down so that a frame takes only a few hundred cycles.
    localparam int clock_rate = 1_600_000;
    localparam int baud_rate  = 100_000;

    localparam int clk_per_bit = clock_rate / baud_rate; // Clock cycles per serial bit.
    localparam int half_bit    = clk_per_bit / 2;        // Offset to the middle of a bit.
    localparam int bit_cnt_w   = $clog2(clk_per_bit);    // Width of the bit-period counter.

    localparam int data_bits  = 8;
    localparam int data_cnt_w = $clog2(data_bits);       // Width of the data bit index.

    // The transmitter drives the line one cycle behind its state.
    typedef enum logic [2:0]
    {
        tx_idle    = 3'b000,
        tx_start   = 3'b001,
        tx_data    = 3'b010,
        tx_stop    = 3'b011,
        tx_cleanup = 3'b100
    } tx_state_t;

    typedef enum logic [1:0]
    {
        rx_idle  = 2'b00,
        rx_start = 2'b01,
        rx_data  = 2'b10,
        rx_stop  = 2'b11
    } rx_state_t;

    // One received frame.
    typedef struct packed
    {
        logic [data_bits-1:0] data;        // Data byte with bit 0 first on the line.
        logic                 frame_error; // Stop bit was sampled low.
    } rx_byte_t;

endpackage

`default_nettype wire

//--- src/uart_tx.sv
`timescale 1ns/1ns
`default_nettype none

module uart_tx
(
    input  logic       clk,
    input  logic       arst,
    input  logic       dv,
    input  logic [7:0] data,
    output logic       active,
    output logic       done,
    output logic       q
);
    import uart_pkg::*;

    tx_state_t             state;
    logic [7:0]            tx_buf;
    logic [bit_cnt_w-1:0]  clk_cnt;
    logic [data_cnt_w-1:0] bit_cnt;
    logic                  bit_end;

    assign bit_end = (clk_cnt == bit_cnt_w'(clk_per_bit - 1)); // Last cycle of a bit period.

    // The byte is captured once per frame, when it is accepted.
    always_ff @(posedge clk)
    begin
        if (state == tx_idle && dv)
        begin
            tx_buf <= data;
        end
    end

    always_ff @(posedge clk or posedge arst)
    begin
        if (arst)
        begin
            state   <= tx_idle;
            clk_cnt <= '0;
            bit_cnt <= '0;
            active  <= 1'b0;
            done    <= 1'b0;
            q       <= 1'b1;
        end
        else
        begin
            case (state)
                tx_idle:
                begin
                    clk_cnt <= '0;
                    bit_cnt <= '0;
                    q       <= 1'b1;
                    if (dv)
                    begin
                        active <= 1'b1;
                        state  <= tx_start;
                    end
                end

                tx_start:
                begin
                    q <= 1'b0;
                    if (bit_end)
                    begin
                        clk_cnt <= '0;
                        state   <= tx_data;
                    end
                    else
                    begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end

                tx_data:
                begin
                    q <= tx_buf[bit_cnt]; // Least significant bit goes first.
                    if (bit_end)
                    begin
                        clk_cnt <= '0;
                        if (bit_cnt == data_cnt_w'(data_bits - 1))
                        begin
                            bit_cnt <= '0;
                            state   <= tx_stop;
                        end
                        else
                        begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                    else
                    begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end

                tx_stop:
                begin
                    q <= 1'b1;
                    if (bit_end)
                    begin
                        clk_cnt <= '0;
                        state   <= tx_cleanup;
                    end
                    else
                    begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end

                tx_cleanup:
                begin
                    // The stop bit on q ends one cycle into this state, then done is held once.
                    if (!done)
                    begin
                        active <= 1'b0;
                        done   <= 1'b1;
                    end
                    else
                    begin
                        done  <= 1'b0;
                        state <= tx_idle;
                    end
                end

                default:
                begin
                    state <= tx_idle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- src/uart_rx.sv
`timescale 1ns/1ns
`default_nettype none

module uart_rx
(
    input  logic               clk,
    input  logic               arst,
    input  logic               rxd,
    output logic               rx_valid,
    output uart_pkg::rx_byte_t rx_byte
);
    import uart_pkg::*;

    logic                  rxd_meta;
    logic                  rxd_sync;
    rx_state_t             state;
    logic [bit_cnt_w-1:0]  clk_cnt;
    logic [data_cnt_w-1:0] bit_cnt;
    logic [data_bits-1:0]  shift;
    logic                  start_mid;
    logic                  bit_mid;

    assign start_mid = (clk_cnt == bit_cnt_w'(half_bit - 1));    // Middle of the start bit.
    assign bit_mid   = (clk_cnt == bit_cnt_w'(clk_per_bit - 1)); // One bit after the last sample.

    // Both flops reset high so that reset does not look like a start bit.
    always_ff @(posedge clk or posedge arst)
    begin
        if (arst)
        begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
        end
        else
        begin
            rxd_meta <= rxd;
            rxd_sync <= rxd_meta;
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == rx_data && bit_mid)
        begin
            shift <= {rxd_sync, shift[data_bits-1:1]}; // First bit ends up in bit 0.
        end
    end

    always_ff @(posedge clk or posedge arst)
    begin
        if (arst)
        begin
            state    <= rx_idle;
            clk_cnt  <= '0;
            bit_cnt  <= '0;
            rx_valid <= 1'b0;
            rx_byte  <= '0;
        end
        else
        begin
            rx_valid <= 1'b0;
            case (state)
                rx_idle:
                begin
                    clk_cnt <= '0;
                    bit_cnt <= '0;
                    if (!rxd_sync)
                    begin
                        state <= rx_start;
                    end
                end

                rx_start:
                begin
                    if (start_mid)
                    begin
                        clk_cnt <= '0;
                        if (rxd_sync)
                        begin
                            state <= rx_idle; // Line is high again, so it was a glitch.
                        end
                        else
                        begin
                            state <= rx_data;
                        end
                    end
                    else
                    begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end

                rx_data:
                begin
                    if (bit_mid)
                    begin
                        clk_cnt <= '0;
                        if (bit_cnt == data_cnt_w'(data_bits - 1))
                        begin
                            bit_cnt <= '0;
                            state   <= rx_stop;
                        end
                        else
                        begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                    else
                    begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end

                rx_stop:
                begin
                    if (bit_mid)
                    begin
                        clk_cnt             <= '0;
                        rx_byte.data        <= shift;
                        rx_byte.frame_error <= ~rxd_sync;
                        rx_valid            <= 1'b1;
                        state               <= rx_idle;
                    end
                    else
                    begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end

                default:
                begin
                    state <= rx_idle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- src/uart_core.sv
`timescale 1ns/1ns
`default_nettype none

module uart_core
(
    input  logic               clk,
    input  logic               arst,
    input  logic               dv,
    input  logic [7:0]         data,
    output logic               active,
    output logic               done,
    output logic               txd,
    input  logic               rxd,
    output logic               rx_valid,
    output uart_pkg::rx_byte_t rx_byte
);

    // The two directions are independent apart from clock and reset.
    uart_tx tx_i
    (
        .clk    (clk),
        .arst   (arst),
        .dv     (dv),
        .data   (data),
        .active (active),
        .done   (done),
        .q      (txd)
    );

    uart_rx rx_i
    (
        .clk      (clk),
        .arst     (arst),
        .rxd      (rxd),
        .rx_valid (rx_valid),
        .rx_byte  (rx_byte)
    );

endmodule

`default_nettype wire

//--- verif/uart_tb.sv
`timescale 1ns/1ns
`default_nettype none

module uart_tb;
    import uart_pkg::*;

    localparam int done_cycle    = 1 + 10 * clk_per_bit; // Edge of done, counted from the dv edge.
    localparam int frame_cycles  = 10 * clk_per_bit;
    localparam int frame_timeout = done_cycle + 4 * clk_per_bit;

    logic     clk;
    logic     arst;
    logic     dv;
    logic     [7:0] data;
    logic     active;
    logic     done;
    logic     txd;
    logic     rxd;
    logic     rx_valid;
    rx_byte_t rx_byte;
    logic     loopback;
    logic     line;

    int       errors   = 0;
    int       timeouts = 0;
    int       rx_count = 0;
    rx_byte_t rx_log[$];

    assign rxd = loopback ? txd : line;

    uart_core dut_i
    (
        .clk      (clk),
        .arst     (arst),
        .dv       (dv),
        .data     (data),
        .active   (active),
        .done     (done),
        .txd      (txd),
        .rxd      (rxd),
        .rx_valid (rx_valid),
        .rx_byte  (rx_byte)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Every received frame is logged with the value it carried at the pulse.
    always @(posedge clk)
    begin
        if (rx_valid)
        begin
            rx_count = rx_count + 1;
            rx_log.push_back(rx_byte);
        end
    end

    task automatic report_mismatch(input string msg);
        errors++;
        $display("MISMATCH at %0t ns: %s", $time, msg);
    endtask

    task automatic report_timeout(input string msg);
        timeouts++;
        $display("Timeout at %0t ns: %s", $time, msg);
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    done_one_cycle: assert property (@(posedge clk) disable iff (arst) done |=> !done)
        else report_mismatch("done stayed high for more than one cycle");

    done_not_active: assert property (@(posedge clk) disable iff (arst) !(done && active))
        else report_mismatch("done and active were high together");

    task automatic check_idle_outputs();
        assert (txd == 1'b1) else report_mismatch("txd is not high after reset");
        assert (active == 1'b0) else report_mismatch("active is not low after reset");
        assert (done == 1'b0) else report_mismatch("done is not low after reset");
        assert (rx_valid == 1'b0) else report_mismatch("rx_valid is not low after reset");
        assert (rx_byte == '0) else report_mismatch("rx_byte is not zero after reset");
    endtask

    // Sends one byte and checks the line at mid-bit, the strobes and the done timing.
    task automatic send_frame(input logic [7:0] value, input logic inject,
                              input logic [7:0] other);
        logic [9:0] frame;
        int         cycle;
        int         fall_cycle;
        int         bit_idx;
        logic       finished;
        frame      = {1'b1, value, 1'b0};
        cycle      = 0;
        fall_cycle = -1;
        bit_idx    = 0;
        finished   = 1'b0;
        data = value;
        dv   = 1'b1;
        next_cycle();
        dv = 1'b0;
        assert (active) else report_mismatch("active did not rise at the dv edge");
        while (!finished && cycle < frame_timeout)
        begin
            next_cycle();
            cycle++;
            if (inject && cycle == 3 * clk_per_bit)
            begin
                data = other; // A second byte while the first is on the line.
                dv   = 1'b1;
            end
            else
            begin
                dv = 1'b0;
            end
            if (fall_cycle < 0 && !txd)
            begin
                fall_cycle = cycle;
                assert (cycle == 1)
                    else report_mismatch($sformatf("txd fell at cycle %0d, expected 1", cycle));
            end
            if (fall_cycle >= 0 && bit_idx < 10
                && cycle == fall_cycle + half_bit + bit_idx * clk_per_bit)
            begin
                assert (txd == frame[bit_idx])
                    else report_mismatch($sformatf("byte %02h bit %0d on txd is %b, expected %b",
                                                   value, bit_idx, txd, frame[bit_idx]));
                bit_idx++;
            end
            if (done)
            begin
                finished = 1'b1;
                assert (cycle == done_cycle)
                    else report_mismatch($sformatf("done rose at cycle %0d, expected %0d",
                                                   cycle, done_cycle));
                assert (bit_idx == 10)
                    else report_mismatch($sformatf("only %0d bits seen before done", bit_idx));
            end
            else
            begin
                assert (active) else report_mismatch("active fell before done");
            end
        end
        if (!finished)
        begin
            report_timeout($sformatf("done never rose after byte %02h was sent", value));
        end
    endtask

    task automatic wait_tx_idle();
        int n;
        n = 0;
        while (done && n < 4)
        begin
            next_cycle();
            n++;
        end
        if (done)
        begin
            report_timeout("done did not fall after its pulse");
        end
    endtask

    task automatic wait_rx(input int target);
        int n;
        n = 0;
        while (rx_count < target && n < 2 * frame_cycles)
        begin
            next_cycle();
            n++;
        end
        if (rx_count < target)
        begin
            report_timeout("the receiver never pulsed rx_valid for the expected frame");
        end
    endtask

    task automatic drive_line_frame(input logic [7:0] value, input logic stop_bit);
        logic [9:0] frame;
        frame = {stop_bit, value, 1'b0};
        for (int i = 0; i < 10; i++)
        begin
            line = frame[i];
            repeat (clk_per_bit) next_cycle();
        end
        line = 1'b1;
    endtask

    initial
    begin
        logic [31:0] rnd;
        logic [7:0]  value;
        int          base;
        void'($urandom(42));
        arst = 1'b1;
        dv = 1'b0;
        data = 8'h00;
        loopback = 1'b1;
        line = 1'b1;
        repeat (3) @(posedge clk);
        #1;
        arst = 1'b0;
        repeat (4) next_cycle();
        check_idle_outputs();

        for (int i = 0; i < 20; i++)
        begin
            rnd   = $urandom();
            value = rnd[7:0];
            base  = rx_count;
            send_frame(value, 1'b0, 8'h00);
            wait_rx(base + 1);
            assert (rx_count == base + 1)
                else report_mismatch($sformatf("%0d frames received for one byte",
                                               rx_count - base));
            if (rx_count > base)
            begin
                assert (rx_log[base].data == value && !rx_log[base].frame_error)
                    else report_mismatch($sformatf("received %02h error %b, expected %02h",
                                         rx_log[base].data, rx_log[base].frame_error, value));
            end
            wait_tx_idle();
        end

        base = rx_count;
        send_frame(8'h3C, 1'b1, 8'h3C ^ 8'hA5);
        wait_tx_idle();
        for (int n = 0; n < 2 * frame_cycles; n++)
        begin
            next_cycle();
            assert (txd == 1'b1) else report_mismatch("ignored dv started a second frame");
        end
        assert (rx_count == base + 1)
            else report_mismatch($sformatf("%0d frames received after ignored dv",
                                           rx_count - base));
        if (rx_count > base)
        begin
            assert (rx_log[base].data == 8'h3C)
                else report_mismatch($sformatf("received %02h, expected 3c", rx_log[base].data));
        end

        loopback = 1'b0;
        repeat (2) next_cycle();
        base = rx_count;
        drive_line_frame(8'h96, 1'b0);
        wait_rx(base + 1);
        if (rx_count > base)
        begin
            assert (rx_log[base].data == 8'h96 && rx_log[base].frame_error)
                else report_mismatch($sformatf("bad stop gave %02h error %b, expected 96 error 1",
                                     rx_log[base].data, rx_log[base].frame_error));
        end
        repeat (2 * clk_per_bit) next_cycle(); // The low stop bit looks like a start for a while.

        base = rx_count;
        line = 1'b0;
        repeat (half_bit - 3) next_cycle();
        line = 1'b1;
        repeat (2 * frame_cycles) next_cycle();
        assert (rx_count == base)
            else report_mismatch("a short low glitch was reported as a frame");

        $display("Errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0)
        begin
            $display("RESULT: PASS");
        end
        else
        begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
src/uart_pkg.sv
src/uart_tx.sv
src/uart_rx.sv
src/uart_core.sv
verif/uart_tb.sv

//--- run.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module uart_tb -f compile.f -o uart_sim

out=$(./obj_dir/uart_sim)
echo "$out"

echo "$out" | grep -qx "RESULT: PASS"
